// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exe
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== exe_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exe_settings.svh"

module exe_alu
    import exe_pkg::*;
(
    input  exe_req_t req,
    output xlen_t    src1,
    output xlen_t    src2,
    input  dxlen_t   product,
    input  div_res_t div_res,
    output xlen_t    out_data
);

    xlen_t sum;
    xlen_t diff;
    xlen_t res;
    logic  word;    // result takes bit 31 as sign

    // operand select
    always_comb begin
        src1 = '0;
        src2 = '0;
        if (req.op != `EXE_OP_NOP) begin
            case (req.src)
                `EXE_SRC_RR: begin
                    src1 = req.rs1;
                    src2 = req.rs2;
                end
                `EXE_SRC_RI: begin
                    src1 = req.rs1;
                    src2 = req.imm;
                end
                `EXE_SRC_PCI: begin
                    src1 = req.pc;
                    src2 = req.imm;
                end
                default: begin
                    src1 = '0;
                    src2 = '0;
                end
            endcase
        end
    end

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    always_comb begin
        res  = '0;
        word = 1'b0;
        case (req.op)
            `EXE_OP_ADD:  res = sum;
            `EXE_OP_SUB:  res = diff;
            `EXE_OP_SLL:  res = src1 << src2[5:0];
            `EXE_OP_SRL:  res = src1 >> src2[5:0];
            `EXE_OP_SRA:  res = $signed(src1) >>> src2[5:0];
            `EXE_OP_XOR:  res = src1 ^ src2;
            `EXE_OP_OR:   res = src1 | src2;
            `EXE_OP_AND:  res = src1 & src2;
            `EXE_OP_SLT:  res = xlen_t'($signed(src1) < $signed(src2));
            `EXE_OP_SLTU: res = xlen_t'(src1 < src2);
            `EXE_OP_ADDW: begin
                res  = sum;
                word = 1'b1;
            end
            `EXE_OP_SUBW: begin
                res  = diff;
                word = 1'b1;
            end
            `EXE_OP_SLLW: begin
                res[31:0] = src1[31:0] << src2[4:0];
                word      = 1'b1;
            end
            `EXE_OP_SRLW: begin
                res[31:0] = src1[31:0] >> src2[4:0];
                word      = 1'b1;
            end
            `EXE_OP_SRAW: begin
                res[31:0] = $signed(src1[31:0]) >>> src2[4:0];
                word      = 1'b1;
            end
            `EXE_OP_MUL:  res = product[`EXE_XLEN-1:0];
            `EXE_OP_MULH, `EXE_OP_MULHSU, `EXE_OP_MULHU: begin
                res = product[2*`EXE_XLEN-1:`EXE_XLEN];   // high half
            end
            `EXE_OP_MULW: begin
                res  = product[`EXE_XLEN-1:0];
                word = 1'b1;
            end
            `EXE_OP_DIV, `EXE_OP_DIVU: res = div_res.quot;
            `EXE_OP_REM, `EXE_OP_REMU: res = div_res.rem;
            `EXE_OP_DIVW, `EXE_OP_DIVUW: begin
                res  = div_res.quot;
                word = 1'b1;
            end
            `EXE_OP_REMW, `EXE_OP_REMUW: begin
                res  = div_res.rem;
                word = 1'b1;
            end
            default: res = '0;
        endcase
    end

    assign out_data = word ? {{(`EXE_XLEN-32){res[31]}}, res[31:0]} : res;

endmodule

`default_nettype wire

// ==== exe_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exe_settings.svh"

module exe_asserts
    import exe_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  in_valid,
    input logic  in_ready,
    input logic  out_valid,
    input logic  out_ready,
    input xlen_t out_data,
    input logic  mul_start,
    input logic  div_start,
    input logic  mul_done,
    input logic  div_done
);

    logic violation = 1'b0;     // raised by any failing property

    quiet_in_reset: assert property (@(posedge clk)
        rst |-> !out_valid && !mul_start && !div_start && !mul_done && !div_done)
    else begin
        $error("stage not quiet during reset");
        violation = 1'b1;
    end

    ready_when_idle: assert property (@(posedge clk) disable iff (rst)
        !in_valid |-> in_ready)
    else begin
        $error("in_ready low without a pending request");
        violation = 1'b1;
    end

    result_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        $error("result changed before it was consumed");
        violation = 1'b1;
    end

    no_accept_when_stalled: assert property (@(posedge clk) disable iff (rst)
        in_valid && !out_ready |-> !in_ready)
    else begin
        $error("request accepted while output was stalled");
        violation = 1'b1;
    end

    // start and done are one cycle wide
    single_pulses: assert property (@(posedge clk) disable iff (rst)
        (mul_start || div_start || mul_done || div_done)
        |=> !(mul_start || div_start || mul_done || div_done))
    else begin
        $error("unit start or done pulse longer than one cycle");
        violation = 1'b1;
    end

endmodule

bind exe_stage exe_asserts asserts_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .mul_start (mul_start),
    .div_start (div_start),
    .mul_done  (mul_done),
    .div_done  (div_done)
);

`default_nettype wire

// ==== exe_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exe_settings.svh"

module exe_ctrl
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  op_t       op,
    output logic      in_ready,
    output logic      out_valid,
    input  logic      out_ready,
    output logic      mul_start,
    output mul_mode_t mul_mode,
    input  logic      mul_done,
    output logic      div_start,
    output logic      div_signed,
    output logic      div_word,
    input  logic      div_done
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        is_mul;
    logic        is_div;

    // decode op into unit and unit flags
    always_comb begin
        is_mul     = 1'b0;
        is_div     = 1'b0;
        mul_mode   = `EXE_MUL_SS;
        div_signed = 1'b0;
        div_word   = 1'b0;
        case (op)
            `EXE_OP_MUL, `EXE_OP_MULH, `EXE_OP_MULW: begin
                is_mul = 1'b1;
            end
            `EXE_OP_MULHSU: begin
                is_mul   = 1'b1;
                mul_mode = `EXE_MUL_SU;
            end
            `EXE_OP_MULHU: begin
                is_mul   = 1'b1;
                mul_mode = `EXE_MUL_UU;
            end
            `EXE_OP_DIV, `EXE_OP_REM: begin
                is_div     = 1'b1;
                div_signed = 1'b1;
            end
            `EXE_OP_DIVU, `EXE_OP_REMU: begin
                is_div = 1'b1;
            end
            `EXE_OP_DIVW, `EXE_OP_REMW: begin
                is_div     = 1'b1;
                div_signed = 1'b1;
                div_word   = 1'b1;
            end
            `EXE_OP_DIVUW, `EXE_OP_REMUW: begin
                is_div   = 1'b1;
                div_word = 1'b1;
            end
            default: begin
                is_mul = 1'b0;
            end
        endcase
    end

    assign mul_start = (state == IDLE) && in_valid && is_mul;
    assign div_start = (state == IDLE) && in_valid && is_div;

    always_comb begin
        out_valid = 1'b0;
        in_ready  = 1'b0;
        case (state)
            IDLE: begin
                if (!in_valid) begin
                    in_ready = 1'b1;
                end else if (!is_mul && !is_div) begin
                    out_valid = 1'b1;       // single cycle, pass straight through
                    in_ready  = out_ready;
                end
            end
            FINISH: begin
                out_valid = 1'b1;
                in_ready  = out_ready;
            end
            default: begin
                out_valid = 1'b0;           // unit busy
            end
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (mul_start) begin
                    state_nxt = MUL;
                end else if (div_start) begin
                    state_nxt = DIV;
                end
            end
            MUL:    if (mul_done) state_nxt = FINISH;
            DIV:    if (div_done) state_nxt = FINISH;
            FINISH: if (out_ready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== exe_div.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exe_settings.svh"

module exe_div
    import exe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     div_start,
    input  logic     div_signed,
    input  logic     div_word,
    input  xlen_t    src1,
    input  xlen_t    src2,
    output logic     div_done,
    output div_res_t div_res
);

    xlen_t              dvd;
    xlen_t              dvs;
    logic               dvd_neg;
    logic               dvs_neg;
    xlen_t              quot;       // dividend shifts out, quotient shifts in
    xlen_t              rem;
    xlen_t              divisor;
    logic               neg_q;
    logic               neg_r;
    logic [`EXE_XLEN:0] shifted;
    logic [`EXE_XLEN:0] trial;
    logic               fits;
    xlen_t              q_next;
    xlen_t              r_next;
    logic               busy;
    logic               last;
    iter_t              cnt;

    // word forms extend the low halves first
    always_comb begin
        dvd = src1;
        dvs = src2;
        if (div_word) begin
            if (div_signed) begin
                dvd = {{(`EXE_XLEN-32){src1[31]}}, src1[31:0]};
                dvs = {{(`EXE_XLEN-32){src2[31]}}, src2[31:0]};
            end else begin
                dvd = {{(`EXE_XLEN-32){1'b0}}, src1[31:0]};
                dvs = {{(`EXE_XLEN-32){1'b0}}, src2[31:0]};
            end
        end
    end

    assign dvd_neg = div_signed && dvd[`EXE_XLEN-1];
    assign dvs_neg = div_signed && dvs[`EXE_XLEN-1];

    assign shifted = {rem, quot[`EXE_XLEN-1]};
    assign trial   = shifted - {1'b0, divisor};
    assign fits    = shifted >= {1'b0, divisor};
    assign q_next  = {quot[`EXE_XLEN-2:0], fits};
    assign r_next  = fits ? trial[`EXE_XLEN-1:0] : shifted[`EXE_XLEN-1:0];

    assign last = busy && (cnt == iter_t'(`EXE_ITER - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            cnt      <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= last;
            if (div_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            quot    <= dvd_neg ? -dvd : dvd;
            rem     <= '0;
            divisor <= dvs_neg ? -dvs : dvs;
            neg_q   <= (dvd_neg ^ dvs_neg) && (dvs != '0);  // x/0 stays all ones
            neg_r   <= dvd_neg;
        end else if (busy) begin
            if (last) begin
                quot <= neg_q ? -q_next : q_next;
                rem  <= neg_r ? -r_next : r_next;
            end else begin
                quot <= q_next;
                rem  <= r_next;
            end
        end
    end

    assign div_res = {quot, rem};

endmodule

`default_nettype wire

// ==== exe_mul.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exe_settings.svh"

module exe_mul
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      mul_start,
    input  mul_mode_t mul_mode,
    input  xlen_t     src1,
    input  xlen_t     src2,
    output logic      mul_done,
    output dxlen_t    product
);

    logic   s1;
    logic   s2;
    logic   neg;
    logic   busy;
    logic   last;
    iter_t  cnt;
    dxlen_t acc;
    dxlen_t mcand;      // shifts left each step
    xlen_t  mplier;
    dxlen_t step;

    // operand signs by mode
    assign s1 = (mul_mode != `EXE_MUL_UU) && src1[`EXE_XLEN-1];
    assign s2 = (mul_mode == `EXE_MUL_SS) && src2[`EXE_XLEN-1];

    assign last = busy && (cnt == iter_t'(`EXE_ITER - 1));
    assign step = acc + (mplier[0] ? mcand : '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            cnt      <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= last;
            if (mul_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand  <= {{`EXE_XLEN{1'b0}}, (s1 ? -src1 : src1)};
            mplier <= s2 ? -src2 : src2;
            acc    <= '0;
            neg    <= s1 ^ s2;
        end else if (busy) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            acc    <= (last && neg) ? -step : step;   // sign applied on final step
        end
    end

    assign product = acc;

endmodule

`default_nettype wire

// ==== exe_pkg.sv ====
`default_nettype none

`include "exe_settings.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0]   xlen_t;
    typedef logic [2*`EXE_XLEN-1:0] dxlen_t;   // full product
    typedef logic [4:0]             op_t;
    typedef logic [1:0]             src_t;
    typedef logic [1:0]             mul_mode_t;
    typedef logic [$clog2(`EXE_ITER)-1:0] iter_t;

    // stage input payload
    typedef struct packed {
        op_t   op;
        src_t  src;
        xlen_t rs1;
        xlen_t rs2;
        xlen_t imm;
        xlen_t pc;
    } exe_req_t;

    typedef struct packed {
        xlen_t quot;
        xlen_t rem;
    } div_res_t;

    typedef enum logic [1:0] {
        IDLE,
        MUL,
        DIV,
        FINISH
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== exe_settings.svh ====
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

`define EXE_XLEN 64
`define EXE_ITER `EXE_XLEN  // one bit per cycle

// operation codes
`define EXE_OP_NOP    5'd0
`define EXE_OP_ADD    5'd1
`define EXE_OP_SUB    5'd2
`define EXE_OP_SLL    5'd3
`define EXE_OP_SRL    5'd4
`define EXE_OP_SRA    5'd5
`define EXE_OP_XOR    5'd6
`define EXE_OP_OR     5'd7
`define EXE_OP_AND    5'd8
`define EXE_OP_SLT    5'd9
`define EXE_OP_SLTU   5'd10
`define EXE_OP_ADDW   5'd11
`define EXE_OP_SUBW   5'd12
`define EXE_OP_SLLW   5'd13
`define EXE_OP_SRLW   5'd14
`define EXE_OP_SRAW   5'd15
`define EXE_OP_MUL    5'd16
`define EXE_OP_MULH   5'd17
`define EXE_OP_MULHSU 5'd18
`define EXE_OP_MULHU  5'd19
`define EXE_OP_MULW   5'd20
`define EXE_OP_DIV    5'd21
`define EXE_OP_DIVU   5'd22
`define EXE_OP_REM    5'd23
`define EXE_OP_REMU   5'd24
`define EXE_OP_DIVW   5'd25
`define EXE_OP_DIVUW  5'd26
`define EXE_OP_REMW   5'd27
`define EXE_OP_REMUW  5'd28

// operand sources
`define EXE_SRC_NONE 2'd0
`define EXE_SRC_RR   2'd1
`define EXE_SRC_RI   2'd2
`define EXE_SRC_PCI  2'd3

// multiplier signedness
`define EXE_MUL_SS 2'd0
`define EXE_MUL_SU 2'd1
`define EXE_MUL_UU 2'd2

`endif

// ==== exe_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exe_settings.svh"

module exe_stage
    import exe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  exe_req_t req,
    output logic     in_ready,
    output logic     out_valid,
    output xlen_t    out_data,
    input  logic     out_ready
);

    logic      mul_start;
    mul_mode_t mul_mode;
    logic      mul_done;
    logic      div_start;
    logic      div_signed;
    logic      div_word;
    logic      div_done;
    xlen_t     src1;
    xlen_t     src2;
    dxlen_t    product;
    div_res_t  div_res;

    exe_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .op         (req.op),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .mul_start  (mul_start),
        .mul_mode   (mul_mode),
        .mul_done   (mul_done),
        .div_start  (div_start),
        .div_signed (div_signed),
        .div_word   (div_word),
        .div_done   (div_done)
    );

    exe_alu alu_i (
        .req      (req),
        .src1     (src1),
        .src2     (src2),
        .product  (product),
        .div_res  (div_res),
        .out_data (out_data)
    );

    exe_mul mul_i (
        .clk       (clk),
        .rst       (rst),
        .mul_start (mul_start),
        .mul_mode  (mul_mode),
        .src1      (src1),
        .src2      (src2),
        .mul_done  (mul_done),
        .product   (product)
    );

    exe_div div_i (
        .clk        (clk),
        .rst        (rst),
        .div_start  (div_start),
        .div_signed (div_signed),
        .div_word   (div_word),
        .src1       (src1),
        .src2       (src2),
        .div_done   (div_done),
        .div_res    (div_res)
    );

endmodule

`default_nettype wire

// ==== tb_exe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exe_settings.svh"

module tb_exe
    import exe_pkg::*;
();

    localparam int CLK_HALF        = 20;
    localparam int RAND_PER_OP     = 6;
    localparam int N_EXTREME       = 6;
    localparam int N_REQ           = 48 * RAND_PER_OP + 13 * N_EXTREME;
    localparam int WATCHDOG_CYCLES = N_REQ * (`EXE_ITER + 4) + 200;
    localparam xlen_t MIN64        = {1'b1, {(`EXE_XLEN-1){1'b0}}};

    logic        clk;
    logic        rst;
    logic        in_valid;
    exe_req_t    req;
    logic        in_ready;
    logic        out_valid;
    xlen_t       out_data;
    logic        out_ready;
    logic [31:0] lfsr = 32'd84;

    exe_stage dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .req       (req),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    always #CLK_HALF clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic xlen_t rand_bits(int n);
        xlen_t v;
        v = '0;
        repeat (n) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[`EXE_XLEN-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic xlen_t sext32(logic [31:0] v);
        return {{(`EXE_XLEN-32){v[31]}}, v};
    endfunction

    function automatic logic is_word(op_t op);
        return (op >= `EXE_OP_ADDW && op <= `EXE_OP_SRAW) || op == `EXE_OP_MULW
            || op >= `EXE_OP_DIVW;
    endfunction

    // corner operand pairs as {a, b}
    function automatic dxlen_t extreme_pair(int i);
        case (i)
            0:       return {MIN64, 64'hffff_ffff_ffff_ffff};    // 64-bit overflow
            1:       return {64'h1234_5678_8000_0000, 64'hffff_ffff_ffff_ffff};
            2:       return {64'hdead_beef_cafe_f00d, 64'h0};    // divide by zero
            3:       return {64'h7fff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff};
            4:       return {MIN64, MIN64};
            default: return {64'h7, 64'hffff_ffff_ffff_fffd};
        endcase
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input op_t op, input xlen_t expected,
                                   input xlen_t actual);
        $display("error: %s op %0d expected %h actual %h", name, op, expected, actual);
        $display("tests failed");
        $fatal(1);
    endtask

    // risc-v semantics on plain operators
    task automatic expect_result(input op_t op, input xlen_t a, input xlen_t b,
                                 output xlen_t e);
        dxlen_t                       p;
        logic signed [`EXE_XLEN-1:0] sa;
        logic signed [`EXE_XLEN-1:0] sb;
        logic signed [`EXE_XLEN-1:0] sq;
        logic signed [31:0]           wa;
        logic signed [31:0]           wb;
        logic signed [31:0]           wq;
        logic                         ovf64;
        logic                         ovf32;
        sa    = a;
        sb    = b;
        wa    = a[31:0];
        wb    = b[31:0];
        ovf64 = (a == MIN64) && (b == '1);
        ovf32 = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);
        e     = '0;
        case (op)
            `EXE_OP_ADD:  e = a + b;
            `EXE_OP_SUB:  e = a - b;
            `EXE_OP_SLL:  e = a << b[5:0];
            `EXE_OP_SRL:  e = a >> b[5:0];
            `EXE_OP_SRA:  e = sa >>> b[5:0];
            `EXE_OP_XOR:  e = a ^ b;
            `EXE_OP_OR:   e = a | b;
            `EXE_OP_AND:  e = a & b;
            `EXE_OP_SLT:  e = {63'b0, sa < sb};
            `EXE_OP_SLTU: e = {63'b0, a < b};
            `EXE_OP_ADDW: e = sext32(a[31:0] + b[31:0]);
            `EXE_OP_SUBW: e = sext32(a[31:0] - b[31:0]);
            `EXE_OP_SLLW: e = sext32(a[31:0] << b[4:0]);
            `EXE_OP_SRLW: e = sext32(a[31:0] >> b[4:0]);
            `EXE_OP_SRAW: e = sext32(wa >>> b[4:0]);
            `EXE_OP_MUL, `EXE_OP_MULH: begin
                p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
                e = (op == `EXE_OP_MUL) ? p[63:0] : p[127:64];
            end
            `EXE_OP_MULHSU: begin
                p = {{64{a[63]}}, a} * {64'b0, b};
                e = p[127:64];
            end
            `EXE_OP_MULHU: begin
                p = {64'b0, a} * {64'b0, b};
                e = p[127:64];
            end
            `EXE_OP_MULW: e = sext32(a[31:0] * b[31:0]);
            `EXE_OP_DIV: begin
                if (b == '0) e = '1;
                else if (ovf64) e = a;
                else begin
                    sq = sa / sb;
                    e  = sq;
                end
            end
            `EXE_OP_REM: begin
                if (b == '0) e = a;
                else if (ovf64) e = '0;
                else begin
                    sq = sa % sb;
                    e  = sq;
                end
            end
            `EXE_OP_DIVU: e = (b == '0) ? '1 : a / b;
            `EXE_OP_REMU: e = (b == '0) ? a : a % b;
            `EXE_OP_DIVW: begin
                if (b[31:0] == '0) e = '1;
                else if (ovf32) e = sext32(a[31:0]);
                else begin
                    wq = wa / wb;
                    e  = sext32(wq);
                end
            end
            `EXE_OP_REMW: begin
                if (b[31:0] == '0) e = sext32(a[31:0]);
                else if (ovf32) e = '0;
                else begin
                    wq = wa % wb;
                    e  = sext32(wq);
                end
            end
            `EXE_OP_DIVUW: e = (b[31:0] == '0) ? '1 : sext32(a[31:0] / b[31:0]);
            `EXE_OP_REMUW: begin
                e = (b[31:0] == '0) ? sext32(a[31:0]) : sext32(a[31:0] % b[31:0]);
            end
            default: e = '0;
        endcase
    endtask

    // starts and ends on a falling edge
    task automatic send_req(input string name, input exe_req_t r);
        xlen_t a;
        xlen_t b;
        xlen_t expected;
        logic  first;
        logic  done;
        case (r.src)
            `EXE_SRC_RR: begin
                a = r.rs1;
                b = r.rs2;
            end
            `EXE_SRC_RI: begin
                a = r.rs1;
                b = r.imm;
            end
            `EXE_SRC_PCI: begin
                a = r.pc;
                b = r.imm;
            end
            default: begin
                a = '0;
                b = '0;
            end
        endcase
        expect_result(r.op, a, b, expected);
        req      = r;
        in_valid = 1'b1;
        first    = 1'b1;
        done     = 1'b0;
        while (!done) begin
            out_ready = |rand_bits(2);     // ready three cycles out of four
            @(posedge clk);
            // the request is taken exactly on the edge that consumes its result
            assert (in_ready == (out_valid && out_ready))
            else stop_run($sformatf("%s op %0d in_ready disagrees with the result handshake",
                                    name, r.op));
            if (first && r.op < `EXE_OP_MUL) begin
                assert (out_valid)
                else stop_run($sformatf("%s op %0d gave no result in its request cycle",
                                        name, r.op));
            end
            first = 1'b0;
            if (out_valid && out_ready) begin
                assert (out_data == expected)
                else report_mismatch(name, r.op, expected, out_data);
                done = 1'b1;
            end
            @(negedge clk);
        end
        in_valid  = 1'b0;
        out_ready = |rand_bits(2);
        @(negedge clk);
    endtask

    task automatic random_req(input string name, input op_t op, input src_t src);
        exe_req_t r;
        r.op  = op;
        r.src = src;
        r.rs1 = rand_bits(64);
        r.rs2 = rand_bits(64);
        r.imm = rand_bits(64);
        r.pc  = rand_bits(64);
        send_req(name, r);
    endtask

    task automatic extreme_req(input op_t op, input int i);
        exe_req_t r;
        dxlen_t   pair;
        pair  = extreme_pair(i);
        r.op  = op;
        r.src = `EXE_SRC_RR;
        r.rs1 = pair[127:64];
        r.rs2 = pair[63:0];
        r.imm = '0;
        r.pc  = '0;
        send_req("extreme", r);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_run("timeout: the stage stopped completing requests");
    end

    // protocol properties live in the bound checker
    initial begin
        wait (dut_i.asserts_i.violation);
        stop_run("a protocol property of the stage was violated");
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        req       = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int o = `EXE_OP_ADD; o <= `EXE_OP_SLTU; o++) begin
            for (int s = `EXE_SRC_RR; s <= `EXE_SRC_PCI; s++) begin
                repeat (RAND_PER_OP) random_req("single", op_t'(o), src_t'(s));
            end
        end
        for (int o = `EXE_OP_ADDW; o <= `EXE_OP_REMUW; o++) begin
            if (is_word(op_t'(o))) begin
                repeat (RAND_PER_OP) random_req("word", op_t'(o), `EXE_SRC_RR);
            end
        end
        for (int o = `EXE_OP_MUL; o <= `EXE_OP_REMUW; o++) begin
            if (!is_word(op_t'(o))) begin
                repeat (RAND_PER_OP) random_req("muldiv", op_t'(o), `EXE_SRC_RR);
            end
        end
        for (int o = `EXE_OP_MUL; o <= `EXE_OP_REMUW; o++) begin
            for (int i = 0; i < N_EXTREME; i++) begin
                extreme_req(op_t'(o), i);
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
exe_pkg.sv
exe_ctrl.sv
exe_alu.sv
exe_mul.sv
exe_div.sv
exe_stage.sv
exe_asserts.sv
tb_exe.sv
